// ==== fft_macros.svh ====
`ifndef FFT_MACROS_SVH
`define FFT_MACROS_SVH

// Transform size and lane layout
`define FFT_N        32
`define FFT_IDX_W    5
`define FFT_LANES    2

// Twiddle coefficients, signed with unity at 2**FFT_COEFF_FRAC
`define FFT_COEFF_W    11
`define FFT_COEFF_FRAC 9

// Pipeline depth, one clock per stage
`define FFT_STAGES  4
`define FFT_LATENCY `FFT_STAGES

////////////////////////////////////////////////////////////////////////////
// Low bits rounded away by each stage quantizer
// Word widths run 10 -> 15 -> 19 -> 21 -> 10
////////////////////////////////////////////////////////////////////////////

`define FFT_SHIFT0 5
`define FFT_SHIFT1 6
`define FFT_SHIFT2 8
`define FFT_SHIFT3 21

`endif

// ==== fft_pkg.sv ====
`include "fft_macros.svh"

`default_nettype none

package fft_pkg;

  // Complex samples at each stage boundary
  typedef struct packed {
    logic signed [9:0] re;
    logic signed [9:0] im;
  } cplx10_t;

  typedef struct packed {
    logic signed [14:0] re;
    logic signed [14:0] im;
  } cplx15_t;

  typedef struct packed {
    logic signed [18:0] re;
    logic signed [18:0] im;
  } cplx19_t;

  typedef struct packed {
    logic signed [20:0] re;
    logic signed [20:0] im;
  } cplx21_t;

  // Twiddle factor
  typedef struct packed {
    logic signed [`FFT_COEFF_W-1:0] re;
    logic signed [`FFT_COEFF_W-1:0] im;
  } coeff_t;

  // Top level bundle, both lanes plus the valid bit
  typedef struct packed {
    logic    valid;
    cplx10_t l0_up;
    cplx10_t l0_down;
    cplx10_t l1_up;
    cplx10_t l1_down;
  } fft_io_t;

endpackage

`default_nettype wire

// ==== twiddle_rom.sv ====
`include "fft_macros.svh"

`default_nettype none

module twiddle_rom (
  input  logic [`FFT_IDX_W-1:0] index,
  output fft_pkg::coeff_t       coeff
);
  import fft_pkg::*;

  localparam real PI    = 3.14159265358979323846;
  localparam real ONE   = real'(1 << `FFT_COEFF_FRAC);
  localparam int  C_MAX = (1 << (`FFT_COEFF_W - 1)) - 1;

  coeff_t table_q [`FFT_N];

  // Nearest integer, ties away from zero, then clamp to a symmetric range
  function automatic logic signed [`FFT_COEFF_W-1:0] round_clamp(input real v);
    int r;
    if (v >= 0.0) begin
      r = $rtoi(v + 0.5);
    end else begin
      r = -$rtoi(-v + 0.5);
    end
    if (r > C_MAX) begin
      r = C_MAX;
    end else if (r < -C_MAX) begin
      r = -C_MAX;
    end
    return r[`FFT_COEFF_W-1:0];
  endfunction

  // W^k = cos(2 pi k / N) - j sin(2 pi k / N)
  function automatic coeff_t make_coeff(input int k);
    real    ang;
    coeff_t c;
    ang  = 2.0 * PI * real'(k) / real'(`FFT_N);
    c.re = round_clamp($cos(ang) * ONE);
    c.im = round_clamp(-$sin(ang) * ONE);
    return c;
  endfunction

  for (genvar k = 0; k < `FFT_N; k++) begin : g_table
    assign table_q[k] = make_coeff(k);
  end

  assign coeff = table_q[index];

endmodule

`default_nettype wire

// ==== cplx_quantizer.sv ====
`default_nettype none

module cplx_quantizer #(
  parameter type in_t  = fft_pkg::cplx21_t,
  parameter type out_t = fft_pkg::cplx10_t,
  parameter int  SHIFT = 1
) (
  input  in_t  din,
  output out_t dout
);

  localparam int IN_W  = $bits(in_t) / 2;
  localparam int OUT_W = $bits(out_t) / 2;

  localparam logic signed [OUT_W-1:0] SAT_MAX = {1'b0, {(OUT_W - 1){1'b1}}};
  localparam logic signed [OUT_W-1:0] SAT_MIN = {1'b1, {(OUT_W - 1){1'b0}}};

  // Round half up, shift, then clip to the output field
  function automatic logic signed [OUT_W-1:0] round_sat(input logic signed [IN_W-1:0] x);
    logic signed [IN_W:0]       rounded;
    logic signed [IN_W:0]       shifted;
    logic [IN_W-OUT_W+1:0]      top;
    rounded = x + ((IN_W + 1)'(1) <<< (SHIFT - 1));
    shifted = rounded >>> SHIFT;
    // Fits when every bit above the output sign matches it
    top = shifted[IN_W:OUT_W-1];
    if ((&top) || (~|top)) begin
      return shifted[OUT_W-1:0];
    end else if (shifted[IN_W]) begin
      return SAT_MIN;
    end else begin
      return SAT_MAX;
    end
  endfunction

  // Real and imaginary parts saturate independently
  always_comb begin
    dout.re = round_sat(din.re);
    dout.im = round_sat(din.im);
  end

endmodule

`default_nettype wire

// ==== fft_butterfly.sv ====
`include "fft_macros.svh"

`default_nettype none

module fft_butterfly #(
  parameter type in_t  = fft_pkg::cplx10_t,
  parameter type out_t = fft_pkg::cplx15_t,
  parameter int  SHIFT = `FFT_SHIFT0
) (
  input  in_t                   up,
  input  in_t                   down,
  input  logic [`FFT_IDX_W-1:0] index,
  output out_t                  up_q,
  output out_t                  down_q
);
  import fft_pkg::*;

  localparam int IN_W = $bits(in_t) / 2;
  // Difference times coefficient, plus one bit for the cross-term sum
  localparam int WW   = IN_W + `FFT_COEFF_W + 2;

  typedef struct packed {
    logic signed [WW-1:0] re;
    logic signed [WW-1:0] im;
  } wide_t;

  logic signed [IN_W:0] sum_re;
  logic signed [IN_W:0] sum_im;
  logic signed [IN_W:0] dif_re;
  logic signed [IN_W:0] dif_im;
  coeff_t               tw;
  wide_t                up_w;
  wide_t                down_w;

  twiddle_rom u_twiddle_rom (
    .index (index),
    .coeff (tw)
  );

  always_comb begin
    sum_re = up.re + down.re;
    sum_im = up.im + down.im;
    dif_re = up.re - down.re;
    dif_im = up.im - down.im;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sum scaled to twiddle unity, difference rotated by W^k
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    up_w.re   = sum_re <<< `FFT_COEFF_FRAC;
    up_w.im   = sum_im <<< `FFT_COEFF_FRAC;
    down_w.re = dif_re * tw.re - dif_im * tw.im;
    down_w.im = dif_re * tw.im + dif_im * tw.re;
  end

  // Back to the stage output width
  cplx_quantizer #(
    .in_t  (wide_t),
    .out_t (out_t),
    .SHIFT (SHIFT)
  ) u_quant_up (
    .din  (up_w),
    .dout (up_q)
  );

  cplx_quantizer #(
    .in_t  (wide_t),
    .out_t (out_t),
    .SHIFT (SHIFT)
  ) u_quant_down (
    .din  (down_w),
    .dout (down_q)
  );

endmodule

`default_nettype wire

// ==== fft_stage.sv ====
`include "fft_macros.svh"

`default_nettype none

module fft_stage #(
  parameter type in_t  = fft_pkg::cplx10_t,
  parameter type out_t = fft_pkg::cplx15_t,
  parameter int  SHIFT = `FFT_SHIFT0,
  parameter int  STAGE = 0
) (
  input  logic clk,
  input  logic rst_n,
  input  logic in_valid,
  input  in_t  in_up    [`FFT_LANES],
  input  in_t  in_down  [`FFT_LANES],
  output logic out_valid,
  output out_t out_up   [`FFT_LANES],
  output out_t out_down [`FFT_LANES]
);

  // Valid sets seen so far, wraps at N/2
  logic [`FFT_IDX_W-2:0] cnt;
  logic [`FFT_IDX_W-1:0] idx     [`FFT_LANES];
  out_t                  bf_up   [`FFT_LANES];
  out_t                  bf_down [`FFT_LANES];

  for (genvar l = 0; l < `FFT_LANES; l++) begin : g_lane
    // (2c + l) << STAGE, truncation gives the mod N
    assign idx[l] = `FFT_IDX_W'({cnt, 1'(l)} << STAGE);

    fft_butterfly #(
      .in_t  (in_t),
      .out_t (out_t),
      .SHIFT (SHIFT)
    ) u_butterfly (
      .up     (in_up[l]),
      .down   (in_down[l]),
      .index  (idx[l]),
      .up_q   (bf_up[l]),
      .down_q (bf_down[l])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      cnt       <= '0;
      out_up    <= '{default: '0};
      out_down  <= '{default: '0};
    end else begin
      out_valid <= in_valid;
      // Gaps leave counter and data untouched
      if (in_valid) begin
        cnt      <= cnt + 1'b1;
        out_up   <= bf_up;
        out_down <= bf_down;
      end
    end
  end

endmodule

`default_nettype wire

// ==== fft_top.sv ====
`include "fft_macros.svh"

`default_nettype none

module fft_top (
  input  logic             clk,
  input  logic             rst_n,
  input  fft_pkg::fft_io_t fft_in,
  output fft_pkg::fft_io_t fft_out
);
  import fft_pkg::*;

  cplx10_t in_up   [`FFT_LANES];
  cplx10_t in_down [`FFT_LANES];

  logic    s0_valid;
  cplx15_t s0_up   [`FFT_LANES];
  cplx15_t s0_down [`FFT_LANES];

  logic    s1_valid;
  cplx19_t s1_up   [`FFT_LANES];
  cplx19_t s1_down [`FFT_LANES];

  logic    s2_valid;
  cplx21_t s2_up   [`FFT_LANES];
  cplx21_t s2_down [`FFT_LANES];

  logic    s3_valid;
  cplx10_t s3_up   [`FFT_LANES];
  cplx10_t s3_down [`FFT_LANES];

  // Split the input bundle into per-lane arrays
  assign in_up   = '{fft_in.l0_up, fft_in.l1_up};
  assign in_down = '{fft_in.l0_down, fft_in.l1_down};

  ////////////////////////////////////////////////////////////////////////////
  // Four stages, 10 -> 15 -> 19 -> 21 -> 10 bits
  ////////////////////////////////////////////////////////////////////////////

  fft_stage #(.in_t(cplx10_t), .out_t(cplx15_t), .SHIFT(`FFT_SHIFT0), .STAGE(0)) u_stage0 (
    .clk (clk), .rst_n (rst_n),
    .in_valid (fft_in.valid), .in_up (in_up), .in_down (in_down),
    .out_valid (s0_valid), .out_up (s0_up), .out_down (s0_down)
  );

  fft_stage #(.in_t(cplx15_t), .out_t(cplx19_t), .SHIFT(`FFT_SHIFT1), .STAGE(1)) u_stage1 (
    .clk (clk), .rst_n (rst_n),
    .in_valid (s0_valid), .in_up (s0_up), .in_down (s0_down),
    .out_valid (s1_valid), .out_up (s1_up), .out_down (s1_down)
  );

  fft_stage #(.in_t(cplx19_t), .out_t(cplx21_t), .SHIFT(`FFT_SHIFT2), .STAGE(2)) u_stage2 (
    .clk (clk), .rst_n (rst_n),
    .in_valid (s1_valid), .in_up (s1_up), .in_down (s1_down),
    .out_valid (s2_valid), .out_up (s2_up), .out_down (s2_down)
  );

  fft_stage #(.in_t(cplx21_t), .out_t(cplx10_t), .SHIFT(`FFT_SHIFT3), .STAGE(3)) u_stage3 (
    .clk (clk), .rst_n (rst_n),
    .in_valid (s2_valid), .in_up (s2_up), .in_down (s2_down),
    .out_valid (s3_valid), .out_up (s3_up), .out_down (s3_down)
  );

  // Last stage back into the output bundle
  assign fft_out = '{
    valid:   s3_valid,
    l0_up:   s3_up[0],
    l0_down: s3_down[0],
    l1_up:   s3_up[1],
    l1_down: s3_down[1]
  };

endmodule

`default_nettype wire

// ==== tb_fft_top.sv ====
`include "fft_macros.svh"

`default_nettype none

module tb_fft_top;
  timeunit 1ns;
  timeprecision 100ps;
  import fft_pkg::*;

  localparam int  MAX_CYCLES = 800;
  localparam real PI         = 3.14159265358979323846;

  logic    clk;
  logic    rst_n;
  fft_io_t fft_in;
  fft_io_t fft_out;
  int      seed;
  int      cycles;
  int      valid_errors;
  int      data_errors;
  int      other_errors;
  int      sets_checked;
  int      stage_cnt [`FFT_STAGES];
  fft_io_t exp_q     [`FFT_LATENCY];
  fft_io_t next_exp;

  fft_top UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .fft_in  (fft_in),
    .fft_out (fft_out)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  // Nearest integer with ties away from zero, clamped to +-1023
  function automatic longint twiddle_part(input real v);
    longint r;
    r = (v >= 0.0) ? $rtoi(v + 0.5) : -$rtoi(-v + 0.5);
    return (r > 1023) ? 1023 : ((r < -1023) ? -1023 : r);
  endfunction

  function automatic longint round_saturate(input longint x, input int shift, input int width);
    longint r;
    longint hi;
    r  = (x + (longint'(1) <<< (shift - 1))) >>> shift;
    hi = (longint'(1) <<< (width - 1)) - 1;
    return (r > hi) ? hi : ((r < -hi - 1) ? -hi - 1 : r);
  endfunction

  function automatic int stage_shift(input int s);
    return (s == 0) ? `FFT_SHIFT0 : (s == 1) ? `FFT_SHIFT1 : (s == 2) ? `FFT_SHIFT2 : `FFT_SHIFT3;
  endfunction

  // Output widths 15, 19, 21 and back to 10
  function automatic int stage_width(input int s);
    return (s == 0) ? 15 : (s == 1) ? 19 : (s == 2) ? 21 : 10;
  endfunction

  // One valid set through all four stages
  task automatic predict(input fft_io_t x, output fft_io_t y);
    longint ur [2];
    longint ui [2];
    longint dr [2];
    longint di [2];
    longint sr;
    longint si;
    longint fr;
    longint fi;
    longint cr;
    longint ci;
    real    ang;
    int     k;
    ur = '{x.l0_up.re, x.l1_up.re};
    ui = '{x.l0_up.im, x.l1_up.im};
    dr = '{x.l0_down.re, x.l1_down.re};
    di = '{x.l0_down.im, x.l1_down.im};
    for (int s = 0; s < `FFT_STAGES; s++) begin
      for (int l = 0; l < 2; l++) begin
        k   = ((2 * stage_cnt[s] + l) << s) % `FFT_N;
        ang = 2.0 * PI * real'(k) / real'(`FFT_N);
        cr  = twiddle_part($cos(ang) * 512.0);
        ci  = twiddle_part(-$sin(ang) * 512.0);
        sr  = (ur[l] + dr[l]) * 512;
        si  = (ui[l] + di[l]) * 512;
        fr  = ur[l] - dr[l];
        fi  = ui[l] - di[l];
        ur[l] = round_saturate(sr, stage_shift(s), stage_width(s));
        ui[l] = round_saturate(si, stage_shift(s), stage_width(s));
        dr[l] = round_saturate(fr * cr - fi * ci, stage_shift(s), stage_width(s));
        di[l] = round_saturate(fr * ci + fi * cr, stage_shift(s), stage_width(s));
      end
      stage_cnt[s] = (stage_cnt[s] + 1) % (`FFT_N / 2);
    end
    y = '{valid: 1'b1, l0_up: '{10'(ur[0]), 10'(ui[0])}, l0_down: '{10'(dr[0]), 10'(di[0])},
          l1_up: '{10'(ur[1]), 10'(ui[1])}, l1_down: '{10'(dr[1]), 10'(di[1])}};
  endtask

  // Expected outputs, one slot per pipeline stage
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_cnt = '{default: 0};
      exp_q     <= '{default: '0};
    end else begin
      next_exp = '0;
      if (fft_in.valid) begin
        predict(fft_in, next_exp);
      end
      exp_q <= '{next_exp, exp_q[0], exp_q[1], exp_q[2]};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks, sampled on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_data(input string name, input cplx10_t expected, input cplx10_t actual);
    $display("error at %0d ns: %s expected (%0d, %0d) got (%0d, %0d)", $time, name,
             expected.re, expected.im, actual.re, actual.im);
    data_errors++;
  endtask

  chk_reset: assert property (@(negedge clk) !rst_n |-> !fft_out.valid)
    else begin
      $display("error at %0d ns: fft_out.valid expected 0 got 1 in reset", $time);
      valid_errors++;
    end

  chk_valid: assert property (@(negedge clk) fft_out.valid == exp_q[3].valid)
    else begin
      $display("error at %0d ns: fft_out.valid expected %0b got %0b", $time,
               exp_q[3].valid, fft_out.valid);
      valid_errors++;
    end

  chk_l0_up: assert property (@(negedge clk) disable iff (!rst_n)
    exp_q[3].valid |-> fft_out.l0_up == exp_q[3].l0_up)
    else report_data("fft_out.l0_up", exp_q[3].l0_up, fft_out.l0_up);

  chk_l0_down: assert property (@(negedge clk) disable iff (!rst_n)
    exp_q[3].valid |-> fft_out.l0_down == exp_q[3].l0_down)
    else report_data("fft_out.l0_down", exp_q[3].l0_down, fft_out.l0_down);

  chk_l1_up: assert property (@(negedge clk) disable iff (!rst_n)
    exp_q[3].valid |-> fft_out.l1_up == exp_q[3].l1_up)
    else report_data("fft_out.l1_up", exp_q[3].l1_up, fft_out.l1_up);

  chk_l1_down: assert property (@(negedge clk) disable iff (!rst_n)
    exp_q[3].valid |-> fft_out.l1_down == exp_q[3].l1_down)
    else report_data("fft_out.l1_down", exp_q[3].l1_down, fft_out.l1_down);

  always @(negedge clk) begin
    if (rst_n && fft_out.valid) begin
      sets_checked++;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TB FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive(input fft_io_t v);
    @(posedge clk);
    #5;
    fft_in = v;
  endtask

  task automatic drive_zeros(input int count, input logic valid);
    fft_io_t v;
    v       = '0;
    v.valid = valid;
    repeat (count) drive(v);
  endtask

  function automatic cplx10_t random_sample();
    cplx10_t c;
    c.re = 10'($random(seed));
    c.im = 10'($random(seed));
    return c;
  endfunction

  function automatic cplx10_t full_scale_sample();
    cplx10_t c;
    c.re = ($random(seed) & 1) ? 10'h1ff : 10'h200;
    c.im = ($random(seed) & 1) ? 10'h1ff : 10'h200;
    return c;
  endfunction

  // About one cycle in four is a gap carrying junk data
  task automatic random_sets(input int count);
    fft_io_t v;
    int      n;
    n = 0;
    while (n < count) begin
      v = '{1'b0, random_sample(), random_sample(), random_sample(), random_sample()};
      if (($random(seed) & 3) != 0) begin
        v.valid = 1'b1;
        n++;
      end
      drive(v);
    end
  endtask

  task automatic full_scale_sets(input int count);
    repeat (count) begin
      drive('{1'b1, full_scale_sample(), full_scale_sample(), full_scale_sample(),
              full_scale_sample()});
    end
  endtask

  // Drops whatever is in flight
  task automatic pulse_reset();
    @(posedge clk);
    #5;
    rst_n  = 1'b0;
    fft_in = '0;
    repeat (2) @(posedge clk);
    #5;
    rst_n = 1'b1;
  endtask

  initial begin
    seed         = 67267;
    cycles       = 0;
    valid_errors = 0;
    data_errors  = 0;
    other_errors = 0;
    sets_checked = 0;
    rst_n        = 1'b0;
    fft_in       = '0;
    repeat (4) @(posedge clk);
    #5;
    rst_n = 1'b1;
    drive_zeros(6, 1'b0);
    // Zero data across every counter value
    drive_zeros(20, 1'b1);
    drive_zeros(2, 1'b0);
    random_sets(100);
    pulse_reset();
    random_sets(100);
    full_scale_sets(48);
    drive_zeros(`FFT_LATENCY + 4, 1'b0);
    if (sets_checked < 200) begin
      $display("only %0d output sets reached the checks, at least 200 were due", sets_checked);
      other_errors++;
    end
    $display("errors: %0d valid, %0d data, %0d other; %0d output sets checked",
             valid_errors, data_errors, other_errors, sets_checked);
    if (valid_errors + data_errors + other_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+.
fft_pkg.sv
twiddle_rom.sv
cplx_quantizer.sv
fft_butterfly.sv
fft_stage.sv
fft_top.sv
tb_fft_top.sv

// ==== Makefile ====
# Verilator build and run for the FFT pipeline testbench

.PHONY: all lint clean

all: obj_dir/Vtb_fft_top
	./obj_dir/Vtb_fft_top | tee sim.log
	@if grep -q "TB FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TB PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

obj_dir/Vtb_fft_top: project.f *.sv *.svh
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	  -f project.f --top-module tb_fft_top

lint:
	verilator --lint-only --timing -Wall --timescale 1ns/1ps \
	  -f project.f --top-module fft_top

clean:
	rm -rf obj_dir sim.log
